// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

    // byte address on the instruction bus
    typedef logic [31:0] addr_t;

    // one instruction word
    typedef logic [31:0] instr_t;

    // pair returned per bus access
    // low word belongs to the lower address
    typedef logic [63:0] instr_pair_t;

    // boot address after reset
    localparam addr_t reset_vector = 32'hbfc0_0000;

    // common exception vector
    localparam addr_t exc_entrance = 32'hbfc0_0380;

    // sequential step, one pair per access
    localparam addr_t pair_stride = 32'd8;

    // offset of the second issue slot
    localparam addr_t instr_bytes = 32'd4;

    // redirect held while fetch is stalled
    // exception and eret share redir_exc
    typedef enum logic [1:0] {
        redir_none   = 2'd0,
        redir_exc    = 2'd1,
        redir_branch = 2'd2
    } redirect_e;

endpackage

// ==== hw/pc_gen.sv ====
`timescale 1ns/1ns

module pc_gen import fetch_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  pc_stall,
    input  logic  exc_valid,
    input  logic  eret_valid,
    input  logic  branch_taken,
    input  addr_t branch_target,
    input  addr_t epc,
    output addr_t pc,
    output logic  pc_misaligned,
    output logic  redirect
);

    redirect_e hold_state;
    addr_t     hold_addr;
    addr_t     pulse_target;
    addr_t     pc_next;
    logic      exc_or_eret;

    assign exc_or_eret = exc_valid | eret_valid;

    // target of a redirect pulse in this cycle
    // exception beats eret beats branch
    always_comb begin
        if (exc_valid) begin
            pulse_target = exc_entrance;
        end else if (eret_valid) begin
            pulse_target = epc;
        end else begin
            pulse_target = branch_target;
        end
    end

    // next pc, held redirect first
    // a fresh exception or eret still beats a held branch
    always_comb begin
        if (hold_state == redir_exc) begin
            pc_next = hold_addr;
        end else if (hold_state == redir_branch && !exc_or_eret) begin
            pc_next = hold_addr;
        end else if (exc_or_eret || branch_taken) begin
            pc_next = pulse_target;
        end else begin
            pc_next = pc + pair_stride;
        end
    end

    // hold state, cleared on the first unstalled edge
    always_ff @(posedge clk) begin
        if (reset) begin
            hold_state <= redir_none;
        end else if (!pc_stall) begin
            hold_state <= redir_none;
        end else if (exc_or_eret) begin
            // later exception overrides a saved branch
            hold_state <= redir_exc;
        end else if (branch_taken && hold_state == redir_none) begin
            hold_state <= redir_branch;
        end
    end

    // saved target, follows the state updates above
    always_ff @(posedge clk) begin
        if (pc_stall && exc_or_eret) begin
            hold_addr <= pulse_target;
        end else if (pc_stall && branch_taken && hold_state == redir_none) begin
            hold_addr <= branch_target;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_vector;
        end else if (!pc_stall) begin
            pc <= pc_next;
        end
    end

    // word alignment check on the fetch address
    assign pc_misaligned = (pc[1:0] != 2'b00);

    // a pending held redirect also counts
    // the stalled pc is still on the wrong path
    assign redirect = exc_or_eret | branch_taken | (hold_state != redir_none);

endmodule

// ==== hw/fetch_hazard.sv ====
`timescale 1ns/1ns

module fetch_hazard (
    input  logic clk,
    input  logic reset,
    input  logic ireq_valid,
    input  logic ireq_addr_ok,
    input  logic decode_stall,
    input  logic redirect,
    output logic pc_stall,
    output logic f1_flush,
    output logic out_stall,
    output logic out_flush,
    output logic late_flush
);

    logic bus_wait;

    // request out but not yet taken by the bus
    assign bus_wait = ireq_valid & ~ireq_addr_ok;

    // pc waits for the bus or for decode
    assign pc_stall = decode_stall | bus_wait;

    // F1 and output move only when decode takes a pair
    assign out_stall = decode_stall;

    // redirect kills everything in front of it
    assign f1_flush  = redirect;
    assign out_flush = redirect;

    // one cycle late flush
    // data for the wrong-path address lands the cycle after
    always_ff @(posedge clk) begin
        if (reset) begin
            late_flush <= 1'b0;
        end else begin
            late_flush <= redirect;
        end
    end

endmodule

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage import fetch_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  addr_t       pc,
    input  logic        pc_misaligned,
    input  logic        ireq_valid,
    input  logic        ireq_addr_ok,
    input  logic        f1_flush,
    input  logic        out_stall,
    input  logic        out_flush,
    input  logic        late_flush,
    input  instr_pair_t iresp_data,
    output addr_t       slot0_pc,
    output addr_t       slot1_pc,
    output instr_t      slot0_instr,
    output instr_t      slot1_instr,
    output logic        slots_valid,
    output logic        fetch_exc
);

    // F1 entry
    addr_t       f1_pc;
    logic        f1_valid;
    logic        f1_exc;

    // pair parked while decode is stalled
    instr_pair_t saved_pair;
    logic        pair_saved;

    instr_pair_t pair_now;
    logic        zero_pair;
    instr_t      word_lo;
    instr_t      word_hi;
    logic        accepted;

    assign accepted = ireq_valid & ireq_addr_ok;

    // F1 control, flush wins over stall
    always_ff @(posedge clk) begin
        if (reset) begin
            f1_valid <= 1'b0;
            f1_exc   <= 1'b0;
        end else if (f1_flush) begin
            f1_valid <= 1'b0;
            f1_exc   <= 1'b0;
        end else if (!out_stall) begin
            // misaligned pc goes down as an exception entry
            f1_valid <= accepted | pc_misaligned;
            f1_exc   <= pc_misaligned;
        end
    end

    always_ff @(posedge clk) begin
        if (!out_stall) begin
            f1_pc <= pc;
        end
    end

    // data is only on the bus the cycle after acceptance
    // keep the first copy until decode moves
    always_ff @(posedge clk) begin
        if (reset) begin
            pair_saved <= 1'b0;
        end else if (f1_flush || !out_stall) begin
            pair_saved <= 1'b0;
        end else if (f1_valid && !pair_saved) begin
            pair_saved <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_stall && f1_valid && !pair_saved) begin
            saved_pair <= iresp_data;
        end
    end

    assign pair_now  = pair_saved ? saved_pair : iresp_data;

    // no real instructions behind a bad pc or a wrong-path pair
    assign zero_pair = f1_exc | late_flush;

    // slot split, low word first
    assign word_lo = zero_pair ? '0 : pair_now[31:0];
    assign word_hi = zero_pair ? '0 : pair_now[63:32];

    // output register control
    // redirect clears it even under stall
    always_ff @(posedge clk) begin
        if (reset) begin
            slots_valid <= 1'b0;
            fetch_exc   <= 1'b0;
        end else if (out_flush) begin
            slots_valid <= 1'b0;
            fetch_exc   <= 1'b0;
        end else if (!out_stall) begin
            slots_valid <= f1_valid;
            fetch_exc   <= f1_exc;
        end
    end

    // payload, held under stall
    always_ff @(posedge clk) begin
        if (!out_stall) begin
            slot0_pc    <= f1_pc;
            slot1_pc    <= f1_pc + instr_bytes;
            slot0_instr <= word_lo;
            slot1_instr <= word_hi;
        end
    end

endmodule

// ==== hw/fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top import fetch_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    output logic        ireq_valid,
    output addr_t       ireq_addr,
    input  logic        ireq_addr_ok,
    input  instr_pair_t iresp_data,
    input  logic        decode_stall,
    input  logic        branch_taken,
    input  addr_t       branch_target,
    input  logic        exc_valid,
    input  logic        eret_valid,
    input  addr_t       epc,
    output addr_t       slot0_pc,
    output instr_t      slot0_instr,
    output addr_t       slot1_pc,
    output instr_t      slot1_instr,
    output logic        slots_valid,
    output logic        fetch_exc
);

    addr_t pc;
    logic  pc_misaligned;
    logic  redirect;
    logic  pc_stall;
    logic  f1_flush;
    logic  out_stall;
    logic  out_flush;
    logic  late_flush;

    // bus request straight from the pc register
    // never request a misaligned address
    assign ireq_addr  = pc;
    assign ireq_valid = ~pc_misaligned;

    pc_gen u_pc_gen (
        .clk           (clk),
        .reset         (reset),
        .pc_stall      (pc_stall),
        .exc_valid     (exc_valid),
        .eret_valid    (eret_valid),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .epc           (epc),
        .pc            (pc),
        .pc_misaligned (pc_misaligned),
        .redirect      (redirect)
    );

    fetch_hazard u_fetch_hazard (
        .clk          (clk),
        .reset        (reset),
        .ireq_valid   (ireq_valid),
        .ireq_addr_ok (ireq_addr_ok),
        .decode_stall (decode_stall),
        .redirect     (redirect),
        .pc_stall     (pc_stall),
        .f1_flush     (f1_flush),
        .out_stall    (out_stall),
        .out_flush    (out_flush),
        .late_flush   (late_flush)
    );

    fetch_stage u_fetch_stage (
        .clk           (clk),
        .reset         (reset),
        .pc            (pc),
        .pc_misaligned (pc_misaligned),
        .ireq_valid    (ireq_valid),
        .ireq_addr_ok  (ireq_addr_ok),
        .f1_flush      (f1_flush),
        .out_stall     (out_stall),
        .out_flush     (out_flush),
        .late_flush    (late_flush),
        .iresp_data    (iresp_data),
        .slot0_pc      (slot0_pc),
        .slot1_pc      (slot1_pc),
        .slot0_instr   (slot0_instr),
        .slot1_instr   (slot1_instr),
        .slots_valid   (slots_valid),
        .fetch_exc     (fetch_exc)
    );

endmodule

// ==== dv/fetch_chk.sv ====
`timescale 1ns/1ns

module fetch_chk import fetch_pkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  ireq_valid,
    input addr_t ireq_addr,
    input logic  slots_valid,
    input addr_t slot0_pc,
    input addr_t slot1_pc
);

    // bus never sees a request for a misaligned pc
    a_aligned_request: assert property (
        @(posedge clk) disable iff (reset)
        ireq_valid |-> (ireq_addr[1:0] == 2'b00)
    ) else $error("bus request for misaligned address %h", ireq_addr);

    // second slot always sits one word above the first
    a_slot_pair: assert property (
        @(posedge clk) disable iff (reset)
        slots_valid |-> (slot1_pc == slot0_pc + 32'd4)
    ) else $error("slot1_pc %h is not slot0_pc %h plus 4", slot1_pc, slot0_pc);

    // reset edge clears the output register
    a_reset_clears: assert property (
        @(posedge clk) reset |=> !slots_valid
    ) else $error("slots_valid high after a reset edge");

endmodule

// ==== dv/fetch_tb.sv ====
`timescale 1ns/1ns

module fetch_tb import fetch_pkg::*; ();

    localparam int clk_period   = 10;
    localparam int reset_cycles = 10;
    // cycle budgets per test
    localparam int t_reset_len  = 40;
    localparam int t_seq_len    = 300;
    localparam int t_stall_len  = 120;
    localparam int t_branch_len = 80;
    localparam int t_prio_len   = 80;
    localparam int t_hold_len   = 120;
    localparam int total_cycles = reset_cycles + t_reset_len + t_seq_len + t_stall_len
                                + t_branch_len + t_prio_len + t_hold_len;
    localparam int seq_pairs    = 32;

    // fixed addresses of the fetch front end
    localparam addr_t boot_addr = 32'hbfc0_0000;
    localparam addr_t exc_addr  = 32'hbfc0_0380;

    logic        clk = 1'b0;
    logic        reset;
    logic        ireq_valid;
    addr_t       ireq_addr;
    logic        ireq_addr_ok;
    instr_pair_t iresp_data = '0;
    logic        decode_stall;
    logic        branch_taken;
    addr_t       branch_target;
    logic        exc_valid;
    logic        eret_valid;
    addr_t       epc;
    addr_t       slot0_pc;
    instr_t      slot0_instr;
    addr_t       slot1_pc;
    instr_t      slot1_instr;
    logic        slots_valid;
    logic        fetch_exc;

    logic [31:0] lfsr = 32'h738d08bd;
    logic        rand_ok;
    addr_t       bus_addr;
    int          errors;
    int          checks;

    // pairs taken by decode in arrival order
    addr_t  got_pc0[$];
    instr_t got_i0[$];
    addr_t  got_pc1[$];
    instr_t got_i1[$];
    logic   got_exc[$];

    always #(clk_period / 2) clk = ~clk;

    fetch_top u_fetch_top (.*);

    bind fetch_top fetch_chk u_fetch_chk (
        .clk         (clk),
        .reset       (reset),
        .ireq_valid  (ireq_valid),
        .ireq_addr   (ireq_addr),
        .slots_valid (slots_valid),
        .slot0_pc    (slot0_pc),
        .slot1_pc    (slot1_pc)
    );

    // memory contents at a byte address
    function automatic instr_t mem_word(input addr_t a);
        return a ^ 32'h5a5a_0000;
    endfunction

    // galois form of x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // bus model returns the pair the cycle after acceptance
    always @(posedge clk) begin
        if (ireq_valid && ireq_addr_ok) begin
            bus_addr = ireq_addr;
            #1;
            iresp_data = {mem_word(bus_addr + 32'd4), mem_word(bus_addr)};
        end
    end

    // decode takes a pair on an edge with slots_valid and no stall
    always @(posedge clk) begin
        if (!reset && slots_valid && !decode_stall) begin
            got_pc0.push_back(slot0_pc);
            got_i0.push_back(slot0_instr);
            got_pc1.push_back(slot1_pc);
            got_i1.push_back(slot1_instr);
            got_exc.push_back(fetch_exc);
        end
    end

    // one clock with inputs moving 1 ns after the edge
    task automatic step();
        @(posedge clk);
        #1;
        if (rand_ok) begin
            lfsr = lfsr_step(lfsr);
            ireq_addr_ok = lfsr[0];
        end
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic clear_pairs();
        got_pc0.delete();
        got_i0.delete();
        got_pc1.delete();
        got_i1.delete();
        got_exc.delete();
    endtask

    task automatic wait_pairs(input int n, input int limit);
        int waited;
        waited = 0;
        while (got_pc0.size() < n && waited < limit) begin
            step();
            waited++;
        end
        if (got_pc0.size() < n) begin
            errors++;
            $display("Timeout at %0t ns: only %0d of %0d pairs reached decode",
                     $time, got_pc0.size(), n);
        end
    endtask

    // expected pair from the memory model
    // zero words for a fetch exception
    task automatic check_pair(input int idx, input addr_t exp_pc, input logic exp_exc);
        instr_t exp_i0;
        instr_t exp_i1;
        if (idx >= got_pc0.size()) begin
            errors++;
            $display("Pair %0d never reached decode", idx);
            return;
        end
        exp_i0 = exp_exc ? '0 : mem_word(exp_pc);
        exp_i1 = exp_exc ? '0 : mem_word(exp_pc + 32'd4);
        check_value(got_pc0[idx], exp_pc, $sformatf("pair %0d slot0_pc", idx));
        check_value(got_i0[idx], exp_i0, $sformatf("pair %0d slot0_instr", idx));
        check_value(got_pc1[idx], exp_pc + 32'd4, $sformatf("pair %0d slot1_pc", idx));
        check_value(got_i1[idx], exp_i1, $sformatf("pair %0d slot1_instr", idx));
        check_value(32'(got_exc[idx]), 32'(exp_exc), $sformatf("pair %0d fetch_exc", idx));
    endtask

    // one-cycle redirect pulse
    // older pairs are dropped afterwards
    task automatic pulse_redirect(input logic exc, input logic eret, input logic br,
                                  input addr_t target, input addr_t ret_addr);
        step();
        exc_valid     = exc;
        eret_valid    = eret;
        branch_taken  = br;
        branch_target = target;
        epc           = ret_addr;
        step();
        exc_valid    = 1'b0;
        eret_valid   = 1'b0;
        branch_taken = 1'b0;
        clear_pairs();
    endtask

    task automatic test_reset();
        check_value(ireq_addr, boot_addr, "ireq_addr after reset");
        check_value(32'(slots_valid), 32'd0, "slots_valid after reset");
        check_value(32'(fetch_exc), 32'd0, "fetch_exc after reset");
        ireq_addr_ok = 1'b1;
        // accepted on the next edge and slots one edge later
        step();
        check_value(32'(slots_valid), 32'd0, "slots_valid on the accept edge");
        step();
        check_value(32'(slots_valid), 32'd1, "slots_valid two edges after accept");
        wait_pairs(1, 20);
        check_pair(0, boot_addr, 1'b0);
    endtask

    task automatic test_sequential();
        pulse_redirect(1'b0, 1'b0, 1'b1, 32'h8000_1000, 32'h0);
        rand_ok = 1'b1;
        wait_pairs(seq_pairs, seq_pairs * 8);
        rand_ok = 1'b0;
        ireq_addr_ok = 1'b1;
        for (int k = 0; k < seq_pairs; k++) begin
            check_pair(k, 32'h8000_1000 + addr_t'(8 * k), 1'b0);
        end
    endtask

    task automatic test_backpressure();
        logic   snap_valid;
        logic   snap_exc;
        addr_t  snap_pc;
        addr_t  snap_pc1;
        instr_t snap_i0;
        instr_t snap_i1;
        addr_t  snap_addr;
        pulse_redirect(1'b0, 1'b0, 1'b1, 32'h8000_2000, 32'h0);
        wait_pairs(2, 20);
        decode_stall = 1'b1;
        snap_valid = slots_valid;
        snap_exc   = fetch_exc;
        snap_pc    = slot0_pc;
        snap_pc1   = slot1_pc;
        snap_i0    = slot0_instr;
        snap_i1    = slot1_instr;
        snap_addr  = ireq_addr;
        check_value(32'(snap_valid), 32'd1, "slots_valid when stall starts");
        repeat (8) begin
            step();
            check_value(32'(slots_valid), 32'(snap_valid), "slots_valid under stall");
            check_value(32'(fetch_exc), 32'(snap_exc), "fetch_exc under stall");
            check_value(slot0_pc, snap_pc, "slot0_pc under stall");
            check_value(slot1_pc, snap_pc1, "slot1_pc under stall");
            check_value(slot0_instr, snap_i0, "slot0_instr under stall");
            check_value(slot1_instr, snap_i1, "slot1_instr under stall");
            check_value(ireq_addr, snap_addr, "ireq_addr under stall");
        end
        decode_stall = 1'b0;
        wait_pairs(8, 40);
        for (int k = 0; k < 8; k++) begin
            check_pair(k, 32'h8000_2000 + addr_t'(8 * k), 1'b0);
        end
    endtask

    task automatic test_branch();
        pulse_redirect(1'b0, 1'b0, 1'b1, 32'h8000_3000, 32'h0);
        wait_pairs(1, 20);
        check_pair(0, 32'h8000_3000, 1'b0);
        // misaligned target gives no bus request
        pulse_redirect(1'b0, 1'b0, 1'b1, 32'h8000_3102, 32'h0);
        check_value(ireq_addr, 32'h8000_3102, "ireq_addr at misaligned target");
        check_value(32'(ireq_valid), 32'd0, "ireq_valid at misaligned target");
        wait_pairs(1, 20);
        check_pair(0, 32'h8000_3102, 1'b1);
    endtask

    task automatic test_priority();
        // exception beats a branch in the same cycle
        pulse_redirect(1'b1, 1'b0, 1'b1, 32'h8000_4000, 32'h0);
        wait_pairs(1, 20);
        check_pair(0, exc_addr, 1'b0);
        pulse_redirect(1'b0, 1'b1, 1'b0, 32'h0, 32'h8000_5010);
        wait_pairs(1, 20);
        check_pair(0, 32'h8000_5010, 1'b0);
    endtask

    task automatic test_held();
        addr_t held_addr;
        ireq_addr_ok = 1'b0;
        step();
        step();
        held_addr = ireq_addr;
        pulse_redirect(1'b0, 1'b0, 1'b1, 32'h8000_6000, 32'h0);
        repeat (4) begin
            check_value(ireq_addr, held_addr, "ireq_addr with redirect held");
            check_value(32'(slots_valid), 32'd0, "slots_valid with redirect held");
            step();
        end
        ireq_addr_ok = 1'b1;
        wait_pairs(1, 20);
        check_pair(0, 32'h8000_6000, 1'b0);
        // exception arriving on top of a held branch
        ireq_addr_ok = 1'b0;
        step();
        step();
        pulse_redirect(1'b0, 1'b0, 1'b1, 32'h8000_7000, 32'h0);
        step();
        pulse_redirect(1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        step();
        step();
        ireq_addr_ok = 1'b1;
        wait_pairs(1, 20);
        check_pair(0, exc_addr, 1'b0);
    endtask

    initial begin
        errors        = 0;
        checks        = 0;
        reset         = 1'b1;
        rand_ok       = 1'b0;
        ireq_addr_ok  = 1'b0;
        decode_stall  = 1'b0;
        branch_taken  = 1'b0;
        branch_target = '0;
        exc_valid     = 1'b0;
        eret_valid    = 1'b0;
        epc           = '0;
        repeat (reset_cycles) step();
        reset = 1'b0;
        test_reset();
        test_sequential();
        test_backpressure();
        test_branch();
        test_priority();
        test_held();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // twice the summed test budgets
    initial begin
        #(total_cycles * 2 * clk_period);
        $display("Watchdog expired at %0t ns, the tests did not complete", $time);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== build.f ====
hw/fetch_pkg.sv
hw/pc_gen.sv
hw/fetch_hazard.sv
hw/fetch_stage.sv
hw/fetch_top.sv
dv/fetch_chk.sv
dv/fetch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
TOP       ?= fetch_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "FAIL"; exit 1; \
	elif ! grep -q "Finished with no errors" $(LOG); then \
		echo "FAIL: simulation ended early"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
